/* obj_pkg.sv */
package obj_pkg;

    // pixel and palette widths
    localparam int PXL_W = 4;
    localparam int PAL_W = 4;
    localparam int ROW_W = 4;   // sprite rows per tile, 16 lines

    typedef logic [PXL_W-1:0] pxl_t;     // colour index, zero is transparent
    typedef logic [PAL_W-1:0] pal_t;
    typedef logic [8:0]       code_t;    // tile code
    typedef logic [13:0]      rom_addr_t; // {code, row, half}
    typedef logic [7:0]       buf_addr_t; // line buffer column
    typedef logic [31:0]      rom_word_t; // eight pixels, low nibble first

    // eight pixels in every ROM word
    localparam int PXL_PER_WORD = $bits(rom_word_t) / PXL_W;

    // never written into the line buffer
    localparam pxl_t ALPHA = '0;

    // columns in one line buffer half
    localparam int LINE_LEN = 2 ** $bits(buf_addr_t);

    // colour PROM depth, indexed by {pal, nibble}
    localparam int PROM_DEPTH = 2 ** (PAL_W + PXL_W);

    // hdump values from 0x100 up to here are still read out
    localparam logic [8:0] HVIS_END = 9'h104;

    // step of the write column under hflip
    localparam buf_addr_t HFLIP_SPAN = buf_addr_t'(2 * PXL_PER_WORD - 1);

endpackage

/* obj_color_prom.sv */
`timescale 1ns/10ps

module obj_color_prom import obj_pkg::*; (
    input  logic       clk,

    // programming port, single cycle writes
    input  logic [7:0] prog_addr,
    input  pxl_t       prog_data,
    input  logic       prog_en,

    // lookup request from the drawer
    input  logic [7:0] color_idx,
    input  buf_addr_t  wr_addr,
    input  logic       wr_en,

    // aligned write into the line buffer
    output pxl_t       buf_wr_data,
    output buf_addr_t  buf_wr_addr,
    output logic       buf_we
);

    pxl_t       mem [PROM_DEPTH];
    logic [7:0] rd_addr;

    always_ff @(posedge clk) begin
        if (prog_en) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // address registered, data read out during the following cycle
    always_ff @(posedge clk) begin
        rd_addr <= color_idx;
    end

    assign buf_wr_data = mem[rd_addr];

    // column and enable follow the lookup by one clk
    always_ff @(posedge clk) begin
        buf_wr_addr <= wr_addr;
        buf_we      <= wr_en;
    end

endmodule

/* obj_line_buffer.sv */
`timescale 1ns/10ps

module obj_line_buffer import obj_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    input  logic      hinit_x,   // swaps draw and display halves

    // draw side
    input  pxl_t      wr_data,
    input  buf_addr_t wr_addr,
    input  logic      we,

    // display side, read then erase
    input  buf_addr_t rd_addr,
    input  logic      rd,
    output pxl_t      rd_data
);

    pxl_t mem [2][LINE_LEN];
    logic draw_half;   // half being drawn, the other one is on screen
    logic solid;

    assign solid = wr_data != ALPHA;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            draw_half <= 1'b0;
        end else if (hinit_x) begin
            draw_half <= ~draw_half;
        end
    end

    // each half has one write port
    // drawing in one, erasing behind the beam in the other
    always_ff @(posedge clk) begin
        for (int h = 0; h < 2; h++) begin
            if (h == int'(draw_half)) begin
                if (we && solid) begin
                    mem[h][wr_addr] <= wr_data;  // transparent pixels keep what is there
                end
            end else if (rd) begin
                mem[h][rd_addr] <= ALPHA;
            end
        end
    end

    // registered read of the display half
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rd_data <= ALPHA;
        end else if (rd) begin
            rd_data <= mem[~draw_half][rd_addr];
        end
    end

endmodule

/* obj_draw.sv */
`timescale 1ns/10ps

module obj_draw import obj_pkg::*; #(
    parameter buf_addr_t HOFFSET = 8'd6
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen2,

    // row request from the scanner
    input  logic             draw,
    output logic             busy,

    input  buf_addr_t        xpos,
    input  logic [ROW_W-1:0] ysub,
    input  pal_t             pal,
    input  logic             hflip,
    input  logic             vflip,
    input  code_t            code,

    // graphics ROM
    output rom_addr_t        rom_addr,
    input  rom_word_t        rom_data,
    output logic             rom_cs,
    input  logic             rom_ok,

    // towards the colour PROM
    output logic [7:0]       color_idx,
    output buf_addr_t        wr_addr,
    output logic             wr_en
);

    localparam int CNT_W = $clog2(PXL_PER_WORD);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PXL_PER_WORD - 1);

    rom_word_t        pxl_data;   // shifts out one nibble per pixel
    logic [CNT_W-1:0] cnt;        // pixels left in the current word
    pal_t             cur_pal;
    logic             cur_hflip;

    logic             start;      // row accepted this cycle
    logic             capture;    // ROM word arrives
    logic             shift;      // one pixel goes out
    logic             last_pxl;

    assign start    = draw && !busy;
    assign capture  = busy && rom_cs && rom_ok;
    assign shift    = busy && !rom_cs;
    assign last_pxl = cnt == '0;

    // low nibble is always the next pixel
    assign color_idx = {cur_pal, pxl_data[PXL_W-1:0]};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            rom_cs    <= 1'b0;
            rom_addr  <= '0;
            wr_en     <= 1'b0;
            wr_addr   <= '0;
            cnt       <= '0;
            cur_hflip <= 1'b0;
        end else if (cen2) begin
            if (start) begin
                // first half is requested straight away
                rom_addr  <= {code, ysub ^ {ROW_W{vflip}}, 1'b0};
                rom_cs    <= 1'b1;
                busy      <= 1'b1;
                cnt       <= CNT_LAST;
                cur_hflip <= hflip;
                wr_addr   <= xpos + HOFFSET + (hflip ? HFLIP_SPAN : buf_addr_t'(0));
            end
            if (capture) begin
                rom_cs <= 1'b0;
                wr_en  <= 1'b1;  // pixel 0 of this word goes out next
            end else if (shift) begin
                wr_addr <= cur_hflip ? wr_addr - 8'd1 : wr_addr + 8'd1;
                cnt     <= cnt - 1'b1;
                if (last_pxl) begin
                    wr_en <= 1'b0;
                    cnt   <= CNT_LAST;
                    if (rom_addr[0]) begin
                        busy <= 1'b0;  // both halves done
                    end else begin
                        rom_addr[0] <= 1'b1;
                        rom_cs      <= 1'b1;
                    end
                end
            end
        end
    end

    // word and palette carry no control meaning
    always_ff @(posedge clk) begin
        if (cen2) begin
            if (start) begin
                cur_pal <= pal;
            end
            if (capture) begin
                pxl_data <= rom_data;
            end else if (shift) begin
                pxl_data <= pxl_data >> PXL_W;
            end
        end
    end

endmodule

/* obj_line_top.sv */
`timescale 1ns/10ps

module obj_line_top import obj_pkg::*; #(
    parameter logic [7:0] HOFFSET = 8'd6
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  logic        cen2,

    // video timing
    input  logic        hinit_x,
    input  logic [8:0]  hdump,

    // scanner handshake and row data
    input  logic        draw,
    output logic        busy,
    input  logic [7:0]  xpos,
    input  logic [3:0]  ysub,
    input  logic [3:0]  pal,
    input  logic        hflip,
    input  logic        vflip,
    input  logic [8:0]  code,

    // colour PROM load
    input  logic [3:0]  prog_data,
    input  logic [7:0]  prog_addr,
    input  logic        prog_en,

    // graphics ROM
    output logic [13:0] rom_addr,
    input  logic [31:0] rom_data,
    output logic        rom_cs,
    input  logic        rom_ok,

    output logic [3:0]  pxl
);

    logic [7:0] color_idx;
    buf_addr_t  wr_addr;
    logic       wr_en;

    pxl_t       buf_wr_data;
    buf_addr_t  buf_wr_addr;
    logic       buf_we;

    logic       buf_clr;

    // visible columns plus the few past 0x100
    assign buf_clr = pxl_cen && (!hdump[8] || hdump < HVIS_END);

    obj_draw #(
        .HOFFSET   ( HOFFSET     )
    ) u_draw (
        .clk       ( clk         ),
        .rst       ( rst         ),
        .cen2      ( cen2        ),
        .draw      ( draw        ),
        .busy      ( busy        ),
        .xpos      ( xpos        ),
        .ysub      ( ysub        ),
        .pal       ( pal         ),
        .hflip     ( hflip       ),
        .vflip     ( vflip       ),
        .code      ( code        ),
        .rom_addr  ( rom_addr    ),
        .rom_data  ( rom_data    ),
        .rom_cs    ( rom_cs      ),
        .rom_ok    ( rom_ok      ),
        .color_idx ( color_idx   ),
        .wr_addr   ( wr_addr     ),
        .wr_en     ( wr_en       )
    );

    obj_color_prom u_prom (
        .clk         ( clk         ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_en     ( prog_en     ),
        .color_idx   ( color_idx   ),
        .wr_addr     ( wr_addr     ),
        .wr_en       ( wr_en       ),
        .buf_wr_data ( buf_wr_data ),
        .buf_wr_addr ( buf_wr_addr ),
        .buf_we      ( buf_we      )
    );

    obj_line_buffer u_buffer (
        .clk     ( clk         ),
        .rst     ( rst         ),
        .hinit_x ( hinit_x     ),
        .wr_data ( buf_wr_data ),
        .wr_addr ( buf_wr_addr ),
        .we      ( buf_we      ),
        .rd_addr ( hdump[7:0]  ),  // column within the line
        .rd      ( buf_clr     ),
        .rd_data ( pxl         )
    );

endmodule

/* obj_line_properties.sv */
`timescale 1ns/10ps

module obj_line_properties import obj_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      cen2,
    input logic      busy,
    input logic      rom_cs,
    input logic      rom_ok,
    input rom_addr_t rom_addr
);

    logic [1:0] ok_cnt;   // ROM words taken in the current row
    logic       taken;
    int         fails = 0;

    assign taken = rom_cs && rom_ok && cen2;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ok_cnt <= '0;
        end else if (!busy) begin
            ok_cnt <= '0;
        end else if (taken) begin
            ok_cnt <= ok_cnt + 2'd1;
        end
    end

    // request held until the ROM answers
    cs_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !taken |=> rom_cs)
        else begin
            fails++;
            $error("rom_cs dropped before rom_ok");
        end

    addr_stable: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !taken |=> $stable(rom_addr))
        else begin
            fails++;
            $error("rom_addr changed while rom_cs was high");
        end

    // one clk after reset is seen the drawer is idle
    reset_idle: assert property (@(posedge clk)
        rst |=> !busy && !rom_cs && rom_addr == '0)
        else begin
            fails++;
            $error("drawer not idle in reset");
        end

    // first request goes out together with busy
    busy_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> rom_cs)
        else begin
            fails++;
            $error("busy rose without a ROM request");
        end

    busy_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> ok_cnt == 2'd2)
        else begin
            fails++;
            $error("busy fell before both ROM words arrived");
        end

    no_cs_idle: assert property (@(posedge clk) disable iff (rst)
        !busy |-> !rom_cs)
        else begin
            fails++;
            $error("rom_cs high while the drawer is idle");
        end

endmodule

/* tb_obj_line.sv */
`timescale 1ns/10ps

module tb_obj_line import obj_pkg::*; ();

    localparam logic [7:0] HOFFSET      = 8'd6;
    localparam logic [8:0] H_LAST       = 9'h10f;  // last hdump of a line
    localparam int         LINE_TIMEOUT = 2000;
    localparam int         BUSY_TIMEOUT = 200;

    logic        clk     = 1'b0;
    logic        rst;
    logic        pxl_cen = 1'b0;
    logic        cen2;
    logic        hinit_x = 1'b0;
    logic [8:0]  hdump   = '0;
    logic        draw;
    logic        busy;
    logic [7:0]  xpos;
    logic [3:0]  ysub;
    logic [3:0]  pal;
    logic        hflip;
    logic        vflip;
    logic [8:0]  code;
    logic [3:0]  prog_data;
    logic [7:0]  prog_addr;
    logic        prog_en;
    logic [13:0] rom_addr;
    logic [31:0] rom_data = '0;
    logic        rom_cs;
    logic        rom_ok   = 1'b0;
    logic [3:0]  pxl;

    integer     seed = 82618;
    pxl_t       prom_tab [PROM_DEPTH];
    pxl_t       ref_draw [LINE_LEN];   // model of the half being drawn
    pxl_t       ref_show [LINE_LEN];   // model of the half on screen
    int         line_cnt;
    int         checks;
    int         errors;
    int         tests;
    int         failed;
    int         test_err0;
    logic       rd_pend;
    logic [7:0] rd_col;
    int         rom_wait;
    logic       rom_half;
    code_t      exp_code;
    logic [3:0] exp_row;

    obj_line_top #(.HOFFSET(HOFFSET)) dut0 (.*);

    bind obj_line_top obj_line_properties props0 (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cen2     ( cen2     ),
        .busy     ( busy     ),
        .rom_cs   ( rom_cs   ),
        .rom_ok   ( rom_ok   ),
        .rom_addr ( rom_addr )
    );

    always #2 clk = ~clk;

    // graphics ROM contents, a fixed mix of the word address
    function automatic rom_word_t rom_word(input rom_addr_t a);
        rom_word_t mix;
        mix = rom_word_t'(a) * 32'h9e37_79b1;
        return mix ^ {a, 4'h0, a};
    endfunction

    // palette 15 makes odd nibbles transparent
    function automatic pxl_t prom_init(input int i);
        pal_t p;
        pxl_t n;
        p = pal_t'(i >> 4);
        n = pxl_t'(i);
        if (n == ALPHA || (p == 4'hf && n[0])) begin
            return ALPHA;
        end
        return pxl_t'((i * 5 + 1) % 15 + 1);
    endfunction

    function automatic int error_count();
        return errors + dut0.props0.fails;
    endfunction

    task automatic check(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("FAIL %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic begin_test();
        test_err0 = error_count();
    endtask

    task automatic end_test(input string name);
        tests++;
        if (error_count() == test_err0) begin
            $display("test %0d %s: passed", tests, name);
        end else begin
            failed++;
            $display("test %0d %s: failed with %0d errors", tests, name,
                     error_count() - test_err0);
        end
    endtask

    task automatic prom_write(input logic [7:0] a, input pxl_t d);
        @(negedge clk);
        prog_addr   = a;
        prog_data   = d;
        prog_en     = 1'b1;
        prom_tab[a] = d;
        @(negedge clk);
        prog_en = 1'b0;
    endtask

    // expected pixels of one row, straight from the drawing rules
    task automatic paint_ref(input logic [7:0] x, input logic [3:0] y, input pal_t p,
                             input logic hf, input logic vf, input code_t c);
        logic [3:0] row;
        rom_word_t  w;
        pxl_t       nib;
        pxl_t       colr;
        logic [7:0] col;
        row = vf ? ~y : y;
        for (int i = 0; i < 2 * PXL_PER_WORD; i++) begin
            w    = rom_word({c, row, i >= PXL_PER_WORD});
            nib  = w[(i % PXL_PER_WORD) * PXL_W +: PXL_W];
            colr = prom_tab[{p, nib}];
            col  = hf ? x + HOFFSET + 8'd15 - 8'(i) : x + HOFFSET + 8'(i);
            if (colr != ALPHA) begin
                ref_draw[col] = colr;  // later solid pixels win
            end
        end
    endtask

    task automatic draw_row(input logic [7:0] x, input logic [3:0] y, input pal_t p,
                            input logic hf, input logic vf, input code_t c);
        int n;
        paint_ref(x, y, p, hf, vf, c);
        exp_code = c;
        exp_row  = vf ? ~y : y;
        @(negedge clk);
        xpos  = x;
        ysub  = y;
        pal   = p;
        hflip = hf;
        vflip = vf;
        code  = c;
        draw  = 1'b1;
        n = 0;
        while (!busy) begin
            @(negedge clk);
            n++;
            if (n > BUSY_TIMEOUT) begin
                abort_run("busy did not rise after draw");
            end
        end
        draw = 1'b0;
        xpos = ~x;   // row is latched by now
        code = ~c;
        pal  = ~p;
        n = 0;
        while (busy) begin
            @(negedge clk);
            n++;
            if (n > BUSY_TIMEOUT) begin
                abort_run("busy stayed high, row never finished");
            end
        end
    endtask

    task automatic wait_line();
        int first_line;
        int n;
        first_line = line_cnt;
        n = 0;
        while (line_cnt == first_line) begin
            @(negedge clk);
            n++;
            if (n > LINE_TIMEOUT) begin
                abort_run("no new line started");
            end
        end
    endtask

    // line timing, pixel check and model half swap
    always @(negedge clk) begin
        if (rst) begin
            rd_pend = 1'b0;
            pxl_cen = 1'b0;
            hinit_x = 1'b0;
            hdump   = '0;
        end else begin
            if (rd_pend && line_cnt >= 2) begin  // both halves erased once by now
                check(pxl === ref_show[rd_col], $sformatf("column %0d shows %h, expected %h",
                      rd_col, pxl, ref_show[rd_col]));
                ref_show[rd_col] = ALPHA;  // read erases the column
            end
            if (hinit_x) begin
                ref_show = ref_draw;
                foreach (ref_draw[i]) begin
                    ref_draw[i] = ALPHA;  // erased while it was shown
                end
                line_cnt++;
            end
            hinit_x = 1'b0;
            if (pxl_cen) begin
                pxl_cen = 1'b0;
                hdump   = (hdump == H_LAST) ? 9'd0 : hdump + 9'd1;
            end else begin
                pxl_cen = 1'b1;
                hinit_x = hdump == H_LAST;
            end
            rd_pend = pxl_cen && hdump < HVIS_END;  // first columns read twice
            rd_col  = hdump[7:0];
        end
    end

    // ROM model with random latency
    always @(negedge clk) begin
        if (rst) begin
            rom_ok   = 1'b0;
            rom_half = 1'b0;
            rom_wait = 0;
        end else if (!rom_cs) begin
            rom_ok   = 1'b0;
            rom_wait = {$random(seed)} % 6;
        end else if (!rom_ok) begin
            if (rom_wait == 0) begin
                check(rom_addr === {exp_code, exp_row, rom_half},
                      $sformatf("rom_addr %h, expected %h", rom_addr,
                      {exp_code, exp_row, rom_half}));
                rom_data = rom_word(rom_addr);
                rom_ok   = 1'b1;
                rom_half = ~rom_half;
            end else begin
                rom_wait--;
            end
        end
    end

    initial begin
        rom_word_t  w;
        logic [7:0] entry;
        pxl_t       new_val;
        rst       = 1'b1;
        cen2      = 1'b1;
        draw      = 1'b0;
        xpos      = '0;
        ysub      = '0;
        pal       = '0;
        hflip     = 1'b0;
        vflip     = 1'b0;
        code      = '0;
        prog_data = '0;
        prog_addr = '0;
        prog_en   = 1'b0;
        foreach (ref_draw[i]) begin
            ref_draw[i] = ALPHA;
            ref_show[i] = ALPHA;
        end

        begin_test();
        repeat (12) @(negedge clk);
        check(!busy && !rom_cs && rom_addr == '0, "drawer not idle during reset");
        check(dut0.buf_we === 1'b0 && pxl === ALPHA, "line buffer active during reset");
        repeat (4) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < PROM_DEPTH; i++) begin
            prom_write(8'(i), prom_init(i));
        end
        while (line_cnt < 3) begin
            wait_line();
        end
        end_test("reset and cleared line");

        begin_test();
        for (int i = 0; i < 7; i++) begin
            draw_row(8'(i * 34 + 3), 4'(i * 5), pal_t'(i + 1), 1'b0, i[0], code_t'(i * 67 + 5));
        end
        wait_line();
        wait_line();
        end_test("rom address and vflip rows");

        begin_test();
        draw_row(8'd0, 4'd7, 4'd2, 1'b0, 1'b0, 9'h1a0);
        draw_row(8'd120, 4'd1, 4'd9, 1'b0, 1'b1, 9'h0ff);
        draw_row(8'd240, 4'd12, 4'd14, 1'b0, 1'b0, 9'h03c);  // wraps past 255
        wait_line();
        wait_line();
        end_test("pixel placement");

        begin_test();
        draw_row(8'd100, 4'd4, 4'd6, 1'b0, 1'b0, 9'h0a5);
        draw_row(8'd40, 4'd4, 4'd6, 1'b1, 1'b0, 9'h0a5);     // mirror of the row above
        draw_row(8'd245, 4'd11, 4'd12, 1'b1, 1'b1, 9'h133);
        wait_line();
        wait_line();
        end_test("hflip and wrap");

        begin_test();
        draw_row(8'd100, 4'd6, 4'd3, 1'b0, 1'b0, 9'h055);
        draw_row(8'd104, 4'd6, 4'hf, 1'b0, 1'b0, 9'h055);
        draw_row(8'd108, 4'd6, 4'hf, 1'b1, 1'b0, 9'h1c2);
        repeat (4) wait_line();  // shown once, then empty twice
        end_test("transparency and erase");

        begin_test();
        draw_row(8'd60, 4'd2, 4'd5, 1'b0, 1'b0, 9'h077);
        wait_line();
        // change the colour of pixel 0 only
        w       = rom_word({9'h077, 4'd2, 1'b0});
        entry   = {4'd5, w[3:0]};
        new_val = prom_tab[entry] + 4'd1;
        if (new_val == ALPHA) begin
            new_val = 4'd1;
        end
        prom_write(entry, new_val);
        draw_row(8'd60, 4'd2, 4'd5, 1'b0, 1'b0, 9'h077);
        draw_row(8'd160, 4'd9, 4'd6, 1'b0, 1'b0, 9'h077);
        wait_line();
        wait_line();
        end_test("prom reprogram");

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks,
                 error_count());
        if (error_count() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* project.f */
obj_pkg.sv
obj_color_prom.sv
obj_line_buffer.sv
obj_draw.sv
obj_line_top.sv
obj_line_properties.sv
tb_obj_line.sv

/* Bender.yml */
package:
  name: obj_line

dependencies: {}

sources:
  # sprite line engine
  - obj_pkg.sv
  - obj_color_prom.sv
  - obj_line_buffer.sv
  - obj_draw.sv
  - obj_line_top.sv

  # testbench and bound protocol checks
  - target: test
    files:
      - obj_line_properties.sv
      - tb_obj_line.sv
